/* rtl/membus_pkg.sv */
package membus_pkg;

	// ----------------------------------------
	// bus widths
	// ----------------------------------------
	localparam int CPU_AW = 23;          // cpu word address, byte bits 23:1
	localparam int DMA_AW = 20;          // dma word address, 2 MB chip space
	localparam int DATA_W = 16;

	// storage per 512 KB bank, upper bits alias
	localparam int BANK_AW    = 10;
	localparam int BANK_WORDS = 1024;
	localparam int NUM_BANKS  = 8;

	// block number sits above the 512 KB word offset
	localparam int BLOCK_LSB = 18;

	// ----------------------------------------
	// address map, top address byte
	// ----------------------------------------
	localparam logic [7:0] CHIP_TOP  = 8'h20;  // chip is 00..1f
	localparam logic [7:0] OVL_TOP   = 8'h08;  // chip block 0 is 00..07
	localparam logic [7:0] SLOW_BASE = 8'hC0;
	localparam logic [7:0] SLOW_TOP  = 8'hD8;  // slow is c0..d7
	localparam logic [7:0] KICK_BASE = 8'hF8;  // kick runs to ff
	localparam logic [7:0] CIA_BASE  = 8'hBF;
	localparam logic [7:0] RTC_BASE  = 8'hDC;

	// ----------------------------------------
	// regions and banks
	// ----------------------------------------
	typedef enum logic [2:0] {
		REGION_NONE  = 3'd0,
		REGION_CHIP  = 3'd1,
		REGION_SLOW  = 3'd2,
		REGION_KICK  = 3'd3,
		REGION_CIA_A = 3'd4,
		REGION_RTC   = 3'd5
	} region_t;

	typedef logic [2:0] bank_t;

	localparam bank_t CHIP_BANK0 = 3'd0;  // chip 0..3
	localparam bank_t SLOW_BANK0 = 3'd4;  // slow 4..6
	localparam bank_t KICK_BANK  = 3'd7;

	// clocks per rtc second, scaled down for simulation
	localparam int RTC_TICK_CYCLES = 64;

endpackage

/* rtl/addr_decoder.sv */
`timescale 1ns/100ps

module addr_decoder (
	input  logic [membus_pkg::CPU_AW-1:0] address,
	input  logic is_write,
	input  logic ovl,
	input  logic rom_write_en,
	output membus_pkg::region_t region,
	output logic write_blocked
);

	logic [7:0] top_byte;   // byte address bits 23:16
	logic in_chip;
	logic in_block0;
	logic in_slow;
	logic in_kick;

	assign top_byte = address[membus_pkg::CPU_AW-1 -: 8];

	// ----------------------------------------
	// range compares
	// ----------------------------------------
	assign in_chip   = top_byte < membus_pkg::CHIP_TOP;
	assign in_block0 = top_byte < membus_pkg::OVL_TOP;
	assign in_slow   = (top_byte >= membus_pkg::SLOW_BASE) &&
	                   (top_byte < membus_pkg::SLOW_TOP);
	assign in_kick   = top_byte >= membus_pkg::KICK_BASE;  // f8..ff

	always_comb begin
		region = membus_pkg::REGION_NONE;
		if (in_chip) begin
			// overlay maps kick over chip block 0, reads only
			if (ovl && in_block0 && !is_write)
				region = membus_pkg::REGION_KICK;
			else
				region = membus_pkg::REGION_CHIP;
		end else if (in_slow) begin
			region = membus_pkg::REGION_SLOW;
		end else if (in_kick) begin
			region = membus_pkg::REGION_KICK;
		end else if (top_byte == membus_pkg::CIA_BASE) begin
			region = membus_pkg::REGION_CIA_A;  // only the overlay clear uses it
		end else if (top_byte == membus_pkg::RTC_BASE) begin
			region = membus_pkg::REGION_RTC;
		end
	end

	// kick is rom unless the host is loading it
	assign write_blocked = is_write && !rom_write_en &&
	                       (region == membus_pkg::REGION_KICK);

endmodule

/* rtl/bank_mapper.sv */
`timescale 1ns/100ps

module bank_mapper (
	input  membus_pkg::region_t region,
	input  logic [1:0] block,
	input  logic [membus_pkg::DMA_AW-1:0] dma_address,
	input  logic dma_sel,
	input  logic [3:0] memory_config,
	output membus_pkg::bank_t bank,
	output logic bank_valid
);

	membus_pkg::region_t eff_region;
	logic [1:0] eff_block;

	// dma only ever reaches chip
	assign eff_region = dma_sel ? membus_pkg::REGION_CHIP : region;
	assign eff_block  = dma_sel ? dma_address[membus_pkg::DMA_AW-1 -: 2] : block;

	always_comb begin
		bank       = membus_pkg::CHIP_BANK0;
		bank_valid = 1'b0;
		case (eff_region)
			membus_pkg::REGION_CHIP: begin
				bank       = membus_pkg::bank_t'(membus_pkg::CHIP_BANK0 + eff_block);
				bank_valid = eff_block <= memory_config[1:0];  // cfg holds count - 1
			end
			membus_pkg::REGION_SLOW: begin
				bank       = membus_pkg::bank_t'(membus_pkg::SLOW_BANK0 + eff_block);
				bank_valid = eff_block < memory_config[3:2];   // 0 means no slow ram
			end
			membus_pkg::REGION_KICK: begin
				bank       = membus_pkg::KICK_BANK;
				bank_valid = 1'b1;
			end
			default: begin
				bank_valid = 1'b0;  // not a ram region
			end
		endcase
	end

endmodule

/* rtl/bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter (
	input  logic clk,
	input  logic reset,
	input  logic cpu_as,
	input  logic cpu_ram_access,   // region lives in the ram
	input  logic cpu_bank_ok,      // ram: bank usable, otherwise: cia-a write
	input  logic dma_req,
	output logic dma_sel,
	output logic ram_cpu_grant,
	output logic cpu_dtack,
	output logic cia_write_grant
);

	logic ack_pending;    // dtack given, waiting for cpu_as to drop
	logic cpu_start;
	logic direct_answer;  // non-ram region, no ram cycle needed
	logic dtack_next;

	// ----------------------------------------
	// grant logic, same cycle
	// ----------------------------------------
	assign cpu_start = cpu_as && !ack_pending;

	// dma owns the ram whenever it asks
	assign dma_sel = dma_req;

	// cpu gets the ram only in a dma free cycle
	assign ram_cpu_grant = cpu_start && cpu_ram_access && !dma_req;

	// cia, rtc and unmapped space bypass the ram and ignore dma
	assign direct_answer = cpu_start && !cpu_ram_access;

	assign cia_write_grant = direct_answer && cpu_bank_ok;

	assign dtack_next = ram_cpu_grant || direct_answer;

	// ----------------------------------------
	// acknowledge
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_dtack   <= 1'b0;
			ack_pending <= 1'b0;
		end else begin
			cpu_dtack <= dtack_next;  // one cycle pulse
			if (dtack_next)
				ack_pending <= 1'b1;
			else if (!cpu_as)
				ack_pending <= 1'b0;  // strobe released, ready for next access
		end
	end

endmodule

/* rtl/chip_ram.sv */
`timescale 1ns/100ps

module chip_ram (
	input  logic clk,
	input  membus_pkg::bank_t bank,
	input  logic [membus_pkg::BANK_AW-1:0] word_address,
	input  logic [membus_pkg::DATA_W-1:0] wdata,
	input  logic hwr,
	input  logic lwr,
	input  logic rd,
	output logic [membus_pkg::DATA_W-1:0] rdata
);

	localparam int DEPTH = membus_pkg::NUM_BANKS * membus_pkg::BANK_WORDS;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int HALF  = membus_pkg::DATA_W / 2;

	logic [membus_pkg::DATA_W-1:0] mem [0:DEPTH-1];
	logic [IDX_W-1:0] idx;

	// bank picks the 1k word slice
	assign idx = {bank, word_address};

	// ----------------------------------------
	// byte lane writes
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (hwr)
			mem[idx][membus_pkg::DATA_W-1:HALF] <= wdata[membus_pkg::DATA_W-1:HALF];
		if (lwr)
			mem[idx][HALF-1:0] <= wdata[HALF-1:0];
	end

	// registered read, old data on a same cycle write
	// zero when idle so the read buses can be ORed
	always_ff @(posedge clk) begin
		if (rd)
			rdata <= mem[idx];
		else
			rdata <= '0;
	end

endmodule

/* rtl/rtc_clock.sv */
`timescale 1ns/100ps

module rtc_clock #(
	parameter int TICK_CYCLES = membus_pkg::RTC_TICK_CYCLES
) (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic [63:0] value,
	input  logic rd,
	input  logic [3:0] nibble_index,
	output logic [membus_pkg::DATA_W-1:0] rdata
);

	localparam int CNT_W = $clog2(TICK_CYCLES + 1);

	logic [63:0] rtc_reg;       // bcd time, seconds in bits 7:0
	logic [CNT_W-1:0] tick_cnt;

	// ----------------------------------------
	// seconds counter
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			rtc_reg  <= '0;
			tick_cnt <= '0;
		end else if (load) begin
			rtc_reg  <= {value[63:8], 8'h00};  // seconds restart at 00
			tick_cnt <= '0;
		end else if (tick_cnt != CNT_W'(TICK_CYCLES - 1)) begin
			tick_cnt <= tick_cnt + 1'b1;
		end else begin
			tick_cnt <= '0;
			if (rtc_reg[3:0] < 4'd9)
				rtc_reg[3:0] <= rtc_reg[3:0] + 4'd1;
			else if (rtc_reg[7:4] < 4'd5)
				rtc_reg[7:0] <= {rtc_reg[7:4] + 4'd1, 4'h0};  // carry into tens
			// 59 holds until the next load
		end
	end

	// one nibble per read, zero extended
	always_ff @(posedge clk) begin
		if (rd)
			rdata <= {{(membus_pkg::DATA_W - 4){1'b0}}, rtc_reg[{nibble_index, 2'b00} +: 4]};
		else
			rdata <= '0;
	end

endmodule

/* rtl/system_control.sv */
`timescale 1ns/100ps

module system_control (
	input  logic clk,
	input  logic reset,
	input  logic user_reset,
	input  logic cia_write_grant,
	output logic sys_reset,
	output logic cpu_reset,
	output logic ovl
);

	logic [1:0] rst_sync;  // two flop reset stretcher

	// ----------------------------------------
	// reset synchroniser
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			rst_sync <= 2'b11;
		else
			rst_sync <= {rst_sync[0], user_reset};
	end

	// low two edges after both sources drop
	assign sys_reset = rst_sync[1];
	assign cpu_reset = rst_sync[1];   // cpu held with the chipset

	// kick overlay, boot fetches come from rom
	always_ff @(posedge clk) begin
		if (reset || sys_reset)
			ovl <= 1'b1;
		else if (cia_write_grant)
			ovl <= 1'b0;  // any cia-a write drops it
	end

endmodule

/* rtl/membus_top.sv */
`timescale 1ns/100ps

module membus_top (
	input  logic clk,
	input  logic reset,
	// cpu port
	input  logic cpu_as,
	input  logic [membus_pkg::CPU_AW-1:0] cpu_address,
	input  logic cpu_rd,
	input  logic cpu_hwr,
	input  logic cpu_lwr,
	input  logic [membus_pkg::DATA_W-1:0] cpu_wdata,
	output logic [membus_pkg::DATA_W-1:0] cpu_rdata,
	output logic cpu_dtack,
	// dma port
	input  logic dma_req,
	input  logic [membus_pkg::DMA_AW-1:0] dma_address,
	input  logic dma_we,
	input  logic [membus_pkg::DATA_W-1:0] dma_wdata,
	output logic [membus_pkg::DATA_W-1:0] dma_rdata,
	// config and system
	input  logic [3:0] memory_config,
	input  logic rom_write_en,
	input  logic rtc_load,
	input  logic [63:0] rtc_value,
	input  logic user_reset,
	output logic cpu_reset,
	output logic ovl
);

	membus_pkg::region_t region;
	membus_pkg::bank_t bank;
	logic write_blocked;
	logic bank_valid;
	logic is_write;
	logic cpu_ram_access;
	logic cia_write;
	logic cpu_bank_ok;
	logic dma_sel;
	logic ram_cpu_grant;
	logic cia_write_grant;
	logic sys_reset;
	logic cpu_go;          // granted and allowed to touch the ram
	logic cpu_ram_q;       // ram data this cycle belongs to the cpu
	logic rtc_rd;
	logic ram_hwr;
	logic ram_lwr;
	logic ram_rd;
	logic [membus_pkg::BANK_AW-1:0] ram_word_address;
	logic [membus_pkg::DATA_W-1:0] ram_wdata;
	logic [membus_pkg::DATA_W-1:0] ram_rdata;
	logic [membus_pkg::DATA_W-1:0] rtc_rdata;

	assign is_write = cpu_hwr || cpu_lwr;

	addr_decoder addr_decoder_inst (
		.address       (cpu_address),
		.is_write      (is_write),
		.ovl           (ovl),
		.rom_write_en  (rom_write_en),
		.region        (region),
		.write_blocked (write_blocked)
	);

	bank_mapper bank_mapper_inst (
		.region        (region),
		.block         (cpu_address[membus_pkg::BLOCK_LSB +: 2]),
		.dma_address   (dma_address),
		.dma_sel       (dma_sel),
		.memory_config (memory_config),
		.bank          (bank),
		.bank_valid    (bank_valid)
	);

	// ----------------------------------------
	// arbitration
	// ----------------------------------------
	assign cpu_ram_access = (region == membus_pkg::REGION_CHIP) ||
	                        (region == membus_pkg::REGION_SLOW) ||
	                        (region == membus_pkg::REGION_KICK);
	assign cia_write   = (region == membus_pkg::REGION_CIA_A) && is_write;
	assign cpu_bank_ok = cpu_ram_access ? (bank_valid && !write_blocked) : cia_write;

	bus_arbiter bus_arbiter_inst (
		.clk             (clk),
		.reset           (sys_reset),
		.cpu_as          (cpu_as),
		.cpu_ram_access  (cpu_ram_access),
		.cpu_bank_ok     (cpu_bank_ok),
		.dma_req         (dma_req),
		.dma_sel         (dma_sel),
		.ram_cpu_grant   (ram_cpu_grant),
		.cpu_dtack       (cpu_dtack),
		.cia_write_grant (cia_write_grant)
	);

	// ----------------------------------------
	// ram port mux, granted master drives it
	// ----------------------------------------
	assign cpu_go = ram_cpu_grant && cpu_bank_ok;  // bad bank still acks, no access

	assign ram_word_address = dma_sel ? dma_address[membus_pkg::BANK_AW-1:0]
	                                  : cpu_address[membus_pkg::BANK_AW-1:0];
	assign ram_wdata = dma_sel ? dma_wdata : cpu_wdata;
	assign ram_hwr   = dma_sel ? (dma_we && bank_valid) : (cpu_go && cpu_hwr);
	assign ram_lwr   = dma_sel ? (dma_we && bank_valid) : (cpu_go && cpu_lwr);
	assign ram_rd    = dma_sel ? (!dma_we && bank_valid) : (cpu_go && cpu_rd);

	chip_ram chip_ram_inst (
		.clk          (clk),
		.bank         (bank),
		.word_address (ram_word_address),
		.wdata        (ram_wdata),
		.hwr          (ram_hwr),
		.lwr          (ram_lwr),
		.rd           (ram_rd),
		.rdata        (ram_rdata)
	);

	// rtc read in the first cycle of the access only
	assign rtc_rd = cpu_as && cpu_rd && !cpu_dtack &&
	                (region == membus_pkg::REGION_RTC);

	rtc_clock #(
		.TICK_CYCLES (membus_pkg::RTC_TICK_CYCLES)
	) rtc_clock_inst (
		.clk          (clk),
		.reset        (sys_reset),
		.load         (rtc_load),
		.value        (rtc_value),
		.rd           (rtc_rd),
		.nibble_index (cpu_address[4:1]),  // byte bits 5:2
		.rdata        (rtc_rdata)
	);

	system_control system_control_inst (
		.clk             (clk),
		.reset           (reset),
		.user_reset      (user_reset),
		.cia_write_grant (cia_write_grant),
		.sys_reset       (sys_reset),
		.cpu_reset       (cpu_reset),
		.ovl             (ovl)
	);

	// ----------------------------------------
	// read data
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (sys_reset)
			cpu_ram_q <= 1'b0;
		else
			cpu_ram_q <= ram_cpu_grant;
	end

	// dma reads in other cycles must not leak to the cpu
	assign cpu_rdata = ({membus_pkg::DATA_W{cpu_ram_q}} & ram_rdata) | rtc_rdata;
	assign dma_rdata = ram_rdata;

endmodule

/* tb/membus_properties.sv */
`timescale 1ns/100ps

module membus_properties (
	input logic clk,
	input logic reset,
	input logic cpu_as,
	input logic cpu_ram_access,
	input logic dma_req,
	input logic cpu_dtack
);

	// ----------------------------------------
	// arbitration rules
	// ----------------------------------------
	dtack_follows_as: assert property (@(posedge clk) disable iff (reset)
		cpu_dtack |-> $past(cpu_as))
		else $error("cpu_dtack without cpu_as on the previous edge");

	// single cycle pulse
	dtack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		cpu_dtack |=> !cpu_dtack)
		else $error("cpu_dtack high two cycles in a row");

	// a ram access is only acknowledged after a cycle free of dma
	dma_first: assert property (@(posedge clk) disable iff (reset)
		cpu_dtack && $past(cpu_ram_access) |-> !$past(dma_req))
		else $error("cpu ram access acknowledged after a dma_req cycle");

endmodule

bind bus_arbiter membus_properties membus_properties_inst (
	.clk            (clk),
	.reset          (reset),
	.cpu_as         (cpu_as),
	.cpu_ram_access (cpu_ram_access),
	.dma_req        (dma_req),
	.cpu_dtack      (cpu_dtack)
);

/* tb/membus_tb.sv */
`timescale 1ns/100ps

module membus_tb;

	localparam int PERIOD      = 100;
	localparam int CFG_OPS     = 48;    // random accesses per memory_config value
	localparam int MIX_OPS     = 300;   // cpu accesses under dma load
	localparam int MAX_BURST   = 8;     // longest dma_req run
	localparam int DTACK_WAIT  = MAX_BURST + 4;
	localparam int TEST_COUNT  = 8 * 1024 + 16 * CFG_OPS + MIX_OPS + 64 * 64;
	localparam int WATCHDOG_NS = TEST_COUNT * DTACK_WAIT * PERIOD;
	localparam int TICK        = membus_pkg::RTC_TICK_CYCLES;

	logic clk;
	logic reset;
	logic cpu_as;
	logic [22:0] cpu_address;
	logic cpu_rd;
	logic cpu_hwr;
	logic cpu_lwr;
	logic [15:0] cpu_wdata;
	logic [15:0] cpu_rdata;
	logic cpu_dtack;
	logic dma_req;
	logic [19:0] dma_address;
	logic dma_we;
	logic [15:0] dma_wdata;
	logic [15:0] dma_rdata;
	logic [3:0] memory_config;
	logic rom_write_en;
	logic rtc_load;
	logic [63:0] rtc_value;
	logic user_reset;
	logic cpu_reset;
	logic ovl;

	// reference model
	logic [15:0] model_mem [0:7][0:1023];  // banks 0-3 chip, 4-6 slow, 7 kick
	logic model_ovl;
	logic [63:0] rtc_model;
	int rtc_load_cycle;                    // cycle count at the load negedge
	logic [31:0] seed = 32'h8f88;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int last_wait = 0;                     // stall cycles of the last cpu access
	logic mix_done;

	membus_top membus_top_inst (
		.clk           (clk),
		.reset         (reset),
		.cpu_as        (cpu_as),
		.cpu_address   (cpu_address),
		.cpu_rd        (cpu_rd),
		.cpu_hwr       (cpu_hwr),
		.cpu_lwr       (cpu_lwr),
		.cpu_wdata     (cpu_wdata),
		.cpu_rdata     (cpu_rdata),
		.cpu_dtack     (cpu_dtack),
		.dma_req       (dma_req),
		.dma_address   (dma_address),
		.dma_we        (dma_we),
		.dma_wdata     (dma_wdata),
		.dma_rdata     (dma_rdata),
		.memory_config (memory_config),
		.rom_write_en  (rom_write_en),
		.rtc_load      (rtc_load),
		.rtc_value     (rtc_value),
		.user_reset    (user_reset),
		.cpu_reset     (cpu_reset),
		.ovl           (ovl)
	);

	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cycles <= cycles + 1;  // posedges so far as seen at a negedge

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [31:0] next_random();
		seed = lcg_next(seed);
		return seed;
	endfunction

	function int random_word();
		return int'(next_random() >> 22);  // top 10 bits
	endfunction

	// cpu word address for a bank with random bits in the aliased part
	function automatic logic [22:0] bank_address(input int bank, input int word,
	                                             input logic [7:0] alias_bits);
		logic [22:0] base;
		if (bank < 4)
			base = 23'({2'(bank), 18'h0});
		else if (bank < 7)
			base = 23'h600000 | 23'({2'(bank - 4), 18'h0});  // slow from c0
		else
			base = 23'h7C0000;                               // kick from f8
		return base | {5'h0, alias_bits, 10'(word)};
	endfunction

	function automatic logic bank_configured(input int bank);
		if (bank < 4)
			return bank <= int'(memory_config[1:0]);  // count minus one
		else if (bank < 7)
			return (bank - 4) < int'(memory_config[3:2]);
		return 1'b1;
	endfunction

	function automatic logic [15:0] expected_read(input int bank, input int word);
		int b;
		b = (model_ovl && bank == 0) ? 7 : bank;  // overlay shows kick
		if (bank_configured(b))
			return model_mem[b][word];
		return 16'h0;
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp,
	                           input logic [15:0] got);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %s: expected %h, actual %h", name, exp, got);
			errors++;
		end
	endtask

	// one cpu access with strobes held until dtack
	task automatic bus_cycle(input logic [22:0] addr, input logic rd, input logic hwr,
	                         input logic lwr, input logic [15:0] wdata,
	                         output logic [15:0] rdata);
		int waited;
		waited = 0;
		cpu_as = 1'b1;
		cpu_address = addr;
		cpu_rd = rd;
		cpu_hwr = hwr;
		cpu_lwr = lwr;
		cpu_wdata = wdata;
		@(negedge clk);
		while (cpu_dtack !== 1'b1 && waited < DTACK_WAIT) begin
			@(negedge clk);  // stalled behind dma
			waited++;
		end
		last_wait = waited;
		assert (cpu_dtack === 1'b1) else begin
			$display("no dtack for cpu access at %h", addr);
			errors++;
		end
		rdata = cpu_rdata;
		cpu_as = 1'b0;
		cpu_rd = 1'b0;
		cpu_hwr = 1'b0;
		cpu_lwr = 1'b0;
		@(negedge clk);
		assert (cpu_dtack === 1'b0) else begin
			$display("second dtack for one cpu access at %h", addr);
			errors++;
		end
	endtask

	task automatic mem_write(input int bank, input int word, input logic hwr,
	                         input logic lwr, input logic [15:0] data);
		logic [15:0] unused;
		bus_cycle(bank_address(bank, word, 8'(next_random())), 1'b0, hwr, lwr, data, unused);
		if (bank_configured(bank) && !(bank == 7 && !rom_write_en)) begin
			if (hwr)
				model_mem[bank][word][15:8] = data[15:8];
			if (lwr)
				model_mem[bank][word][7:0] = data[7:0];
		end
	endtask

	task automatic mem_read(input string name, input int bank, input int word);
		logic [15:0] got;
		bus_cycle(bank_address(bank, word, 8'(next_random())), 1'b1, 1'b0, 1'b0, 16'h0, got);
		check_value(name, expected_read(bank, word), got);
	endtask

	task automatic random_op(input string name, input int first_bank);
		logic [31:0] r;
		int bank;
		r = next_random();
		bank = first_bank + int'(r[31:24]) % (8 - first_bank);
		if (r[23])
			mem_write(bank, int'(r[9:0]), r[22] | !r[21], r[21], 16'(next_random() >> 8));
		else
			mem_read(name, bank, int'(r[9:0]));
	endtask

	// nibble read with seconds expected from the edges since the load
	task automatic rtc_read_check(input int idx);
		int issue_cycle;
		int secs;
		logic [63:0] t;
		logic [15:0] got;
		issue_cycle = cycles;
		bus_cycle(23'h6E0000 | 23'(idx << 1), 1'b1, 1'b0, 1'b0, 16'h0, got);
		secs = (issue_cycle - rtc_load_cycle - 1) / TICK;
		if (secs > 59)
			secs = 59;
		t = {rtc_model[63:8], 4'(secs / 10), 4'(secs % 10)};
		check_value("rtc nibble", {12'h0, t[idx * 4 +: 4]}, got);
	endtask

	task automatic rtc_after(input int secs);
		while (cycles < rtc_load_cycle + 1 + secs * TICK + TICK / 2)
			@(negedge clk);  // mid second and away from the tick
		rtc_read_check(0);
		rtc_read_check(1);
	endtask

	// dma bursts on chip bank 0 while the cpu stays off it
	task automatic dma_traffic(input logic [31:0] s);
		int left;
		logic pending;
		logic [15:0] pend_exp;
		logic [9:0] word;
		left = 0;
		pending = 1'b0;
		while (!mix_done || pending) begin
			@(negedge clk);
			if (pending)
				check_value("dma read", pend_exp, dma_rdata);  // one cycle later
			pending = 1'b0;
			dma_req = 1'b0;
			dma_we = 1'b0;
			s = lcg_next(s);
			if (left > 0 && !mix_done) begin
				word = s[25:16];
				dma_req = 1'b1;
				dma_address = {2'b00, s[7:0], word};
				dma_we = s[31];
				dma_wdata = s[15:0];
				if (s[31]) begin
					model_mem[0][word] = s[15:0];
				end else begin
					pending = 1'b1;
					pend_exp = model_mem[0][word];
				end
				left--;
			end else begin
				left = int'(s[31:29]) + 1;  // idle cycle then a burst of 1..8
			end
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		logic [15:0] got;
		int i;
		int cfg;
		int ovl_words [0:7];
		clk = 1'b0;
		reset = 1'b1;
		cpu_as = 1'b0;
		cpu_address = '0;
		cpu_rd = 1'b0;
		cpu_hwr = 1'b0;
		cpu_lwr = 1'b0;
		cpu_wdata = '0;
		dma_req = 1'b0;
		dma_address = '0;
		dma_we = 1'b0;
		dma_wdata = '0;
		memory_config = 4'hf;
		rom_write_en = 1'b0;
		rtc_load = 1'b0;
		rtc_value = '0;
		user_reset = 1'b0;
		model_ovl = 1'b1;
		mix_done = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_value("cpu_reset held", 16'h1, 16'(cpu_reset));
		check_value("ovl after reset", 16'h1, 16'(ovl));
		@(negedge clk);
		check_value("cpu_reset release", 16'h0, 16'(cpu_reset));
		check_value("dtack idle", 16'h0, 16'(cpu_dtack));

		// fill every bank with kick writable and a pattern over the whole address
		rom_write_en = 1'b1;
		for (i = 0; i < 8 * 1024; i++)
			mem_write(i / 1024, i % 1024, 1'b1, 1'b1, 16'(i * 32'h9e37) ^ 16'h5a3c);
		rom_write_en = 1'b0;

		// overlay reads until a cia-a write drops it
		for (i = 0; i < 8; i++) begin
			ovl_words[i] = random_word();
			mem_read("overlay read", 0, ovl_words[i]);
		end
		bus_cycle(23'h5F8000 | 23'(next_random() & 32'h7fff), 1'b0, 1'b1, 1'b1, 16'hffff, got);
		model_ovl = 1'b0;
		check_value("ovl clear", 16'h0, 16'(ovl));
		bus_cycle(23'h5F8000, 1'b1, 1'b0, 1'b0, 16'h0, got);
		check_value("cia read", 16'h0, got);
		for (i = 0; i < 8; i++)
			mem_read("chip block 0", 0, ovl_words[i]);

		// kick is rom without rom_write_en
		for (i = 0; i < 8; i++) begin
			cfg = random_word();
			mem_write(7, cfg, 1'b1, 1'b1, 16'(next_random()));
			mem_read("kick protect", 7, cfg);
		end

		// ----------------------------------------
		// every memory_config value
		// ----------------------------------------
		for (cfg = 0; cfg < 16; cfg++) begin
			memory_config = 4'(cfg);
			rom_write_en = (cfg % 4 == 3);
			repeat (CFG_OPS)
				random_op("config access", 0);
		end
		rom_write_en = 1'b0;
		memory_config = 4'hf;

		// cpu traffic against dma bursts
		fork
			dma_traffic(next_random());
			begin
				for (i = 0; i < MIX_OPS; i++) begin
					random_op("dma mix", 1);
					if (i % 16 == 0) begin
						bus_cycle(23'h5F8000, 1'b1, 1'b0, 1'b0, 16'h0, got);
						check_value("cia read under dma", 16'h0, got);
						check_value("cia stall under dma", 16'h0, 16'(last_wait));
					end
				end
				mix_done = 1'b1;
			end
		join
		for (i = 0; i < 16; i++)
			mem_read("dma written", 0, random_word());

		// ----------------------------------------
		// rtc
		// ----------------------------------------
		rtc_value = {next_random(), next_random()};
		rtc_model = {rtc_value[63:8], 8'h00};
		rtc_load_cycle = cycles;
		rtc_load = 1'b1;
		@(negedge clk);
		rtc_load = 1'b0;
		for (i = 0; i < 16; i++)
			rtc_read_check(i);
		rtc_after(1);
		rtc_after(3);
		rtc_after(61);  // held at 59

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// watchdog bound by test count and longest stall
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, simulation stuck", WATCHDOG_NS);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Verification failed");
		$finish;
	end

endmodule

/* files.f */
rtl/membus_pkg.sv
rtl/addr_decoder.sv
rtl/bank_mapper.sv
rtl/bus_arbiter.sv
rtl/chip_ram.sv
rtl/rtc_clock.sv
rtl/system_control.sv
rtl/membus_top.sv
tb/membus_properties.sv
tb/membus_tb.sv

/* run.sh */
#!/bin/sh
# compile with verilator and run the membus testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module membus_tb -f files.f

out=$(./obj_dir/Vmembus_tb)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
